// File: axi_pkg.sv
package axi_pkg;

    localparam int id_w     = 4;
    localparam int addr_w   = 32;
    localparam int data_w   = 64;
    localparam int strb_w   = data_w / 8;
    localparam int extras_w = 8;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic [id_w-1:0]     id;
        logic [addr_w-1:0]   addr;
        logic [7:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
        logic [extras_w-1:0] extras;  // user sideband, passed through untouched.
    } aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } b_t;

endpackage

// File: split_pkg.sv
package split_pkg;

    localparam int num_ports = 4;
    localparam int sel_w     = 2;  // top address bits that pick the port.

    typedef logic [sel_w-1:0] port_t;

    localparam int aw_depth        = 4;
    localparam int w_depth         = 8;
    localparam int order_depth     = 8;
    localparam int b_depth         = 2;
    localparam int max_outstanding = 4;
    localparam int cnt_w           = 3;  // must hold max_outstanding.

    // response waiting upstream, tagged with the port it came from.
    typedef struct packed {
        axi_pkg::b_t b;
        port_t       port;
    } tagged_b_t;

endpackage

// File: sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     empty
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int occ_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [occ_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // a push into a full FIFO is ignored.
    assign do_pop  = pop && !empty;
    assign full    = (count == occ_w'(depth));
    assign empty   = (count == '0);
    assign dout    = mem[rd_ptr];  // head straight from the storage flops.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: aw_router.sv
module aw_router (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             awvalid,
    output logic             awready,
    input  axi_pkg::aw_t     aw,
    input  logic             can_issue [split_pkg::num_ports],
    input  logic             order_full,
    output logic             order_push,
    output split_pkg::port_t order_port,
    output logic             m_awvalid [split_pkg::num_ports],
    input  logic             m_awready [split_pkg::num_ports],
    output axi_pkg::aw_t     m_aw [split_pkg::num_ports],
    output logic             issue [split_pkg::num_ports]
);
    axi_pkg::aw_t     head;
    axi_pkg::aw_t     fwd;
    split_pkg::port_t tgt;
    logic             aw_full;
    logic             aw_empty;
    logic             go;
    logic             pop;

    sync_fifo #(
        .payload_t(axi_pkg::aw_t),
        .depth    (split_pkg::aw_depth)
    ) aw_fifo_i (
        .clk  (clk),
        .rst_n(rst_n),
        .push (awvalid && awready),
        .din  (aw),
        .pop  (pop),
        .dout (head),
        .full (aw_full),
        .empty(aw_empty)
    );

    assign awready = !aw_full;
    assign tgt     = head.addr[axi_pkg::addr_w-1 -: split_pkg::sel_w];

    // held until the port may take another write and the owner can be logged.
    assign go = !aw_empty && can_issue[tgt] && !order_full;

    always_comb begin
        fwd      = head;
        fwd.addr = {head.addr[axi_pkg::addr_w-split_pkg::sel_w-1:0], {split_pkg::sel_w{1'b0}}};
    end

    always_comb begin
        pop = 1'b0;
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            m_awvalid[p] = go && (tgt == split_pkg::port_t'(p));
            m_aw[p]      = m_awvalid[p] ? fwd : '0;  // idle ports see zeros.
            issue[p]     = m_awvalid[p] && m_awready[p];
            pop          = pop || issue[p];
        end
    end

    assign order_push = pop;
    assign order_port = tgt;

endmodule

// File: w_steer.sv
module w_steer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             order_empty,
    input  split_pkg::port_t order_port,
    output logic             order_pop,
    input  logic             w_empty,
    input  axi_pkg::w_t      w_head,
    output logic             w_pop,
    output logic             m_wvalid [split_pkg::num_ports],
    input  logic             m_wready [split_pkg::num_ports],
    output axi_pkg::w_t      m_w [split_pkg::num_ports]
);
    typedef enum logic {
        st_idle,
        st_burst
    } state_t;

    state_t           state;
    split_pkg::port_t owner;
    logic             beat_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            owner <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (!order_empty) begin
                        owner <= order_port;  // oldest burst not yet written.
                        state <= st_burst;
                    end
                end
                st_burst: begin
                    if (beat_done && w_head.last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        beat_done = 1'b0;
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            m_wvalid[p] = (state == st_burst) && !w_empty && (owner == split_pkg::port_t'(p));
            m_w[p]      = m_wvalid[p] ? w_head : '0;
            beat_done   = beat_done || (m_wvalid[p] && m_wready[p]);
        end
    end

    assign w_pop     = beat_done;
    assign order_pop = beat_done && w_head.last;  // burst finished, drop its owner.

endmodule

// File: outstanding_counter.sv
module outstanding_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic issue [split_pkg::num_ports],
    input  logic retire [split_pkg::num_ports],
    output logic can_issue [split_pkg::num_ports]
);
    logic [split_pkg::cnt_w-1:0] cnt [split_pkg::num_ports];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < split_pkg::num_ports; p++) begin
                cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < split_pkg::num_ports; p++) begin
                // issue and retire together cancel out.
                if (issue[p] && !retire[p]) begin
                    cnt[p] <= cnt[p] + 1'b1;
                end else if (retire[p] && !issue[p]) begin
                    cnt[p] <= cnt[p] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            can_issue[p] = (int'(cnt[p]) < split_pkg::max_outstanding);
        end
    end

endmodule

// File: b_merge.sv
module b_merge (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        m_bvalid [split_pkg::num_ports],
    output logic        m_bready [split_pkg::num_ports],
    input  axi_pkg::b_t m_b [split_pkg::num_ports],
    output logic        bvalid,
    input  logic        bready,
    output axi_pkg::b_t b,
    output logic        retire [split_pkg::num_ports]
);
    axi_pkg::b_t          pq_head [split_pkg::num_ports];
    logic                 pq_full [split_pkg::num_ports];
    logic                 pq_empty [split_pkg::num_ports];
    logic                 pq_pop [split_pkg::num_ports];
    split_pkg::port_t     sel;
    logic                 found;
    logic                 move;
    split_pkg::tagged_b_t entry;
    split_pkg::tagged_b_t mq_head;
    logic                 mq_full;
    logic                 mq_empty;

    for (genvar p = 0; p < split_pkg::num_ports; p++) begin : g_port_q
        sync_fifo #(
            .payload_t(axi_pkg::b_t),
            .depth    (split_pkg::b_depth)
        ) b_fifo_i (
            .clk  (clk),
            .rst_n(rst_n),
            .push (m_bvalid[p] && m_bready[p]),
            .din  (m_b[p]),
            .pop  (pq_pop[p]),
            .dout (pq_head[p]),
            .full (pq_full[p]),
            .empty(pq_empty[p])
        );
        assign m_bready[p] = !pq_full[p];
    end

    // port 0 wins; scan from the top so the lowest index is kept.
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int p = split_pkg::num_ports - 1; p >= 0; p--) begin
            if (!pq_empty[p]) begin
                found = 1'b1;
                sel   = split_pkg::port_t'(p);
            end
        end
        move = found && !mq_full;
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            pq_pop[p] = move && (sel == split_pkg::port_t'(p));
        end
        entry.b    = pq_head[sel];
        entry.port = sel;
    end

    sync_fifo #(
        .payload_t(split_pkg::tagged_b_t),
        .depth    (split_pkg::b_depth)
    ) merged_fifo_i (
        .clk  (clk),
        .rst_n(rst_n),
        .push (move),
        .din  (entry),
        .pop  (bvalid && bready),
        .dout (mq_head),
        .full (mq_full),
        .empty(mq_empty)
    );

    assign bvalid = !mq_empty;
    assign b      = mq_head.b;

    always_comb begin
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            retire[p] = bvalid && bready && (mq_head.port == split_pkg::port_t'(p));
        end
    end

endmodule

// File: axi_wr_splitter.sv
module axi_wr_splitter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [axi_pkg::id_w-1:0]     awid,
    input  logic [axi_pkg::addr_w-1:0]   awaddr,
    input  logic [7:0]                   awlen,
    input  logic [2:0]                   awsize,
    input  logic [1:0]                   awburst,
    input  logic [axi_pkg::extras_w-1:0] awextras,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [axi_pkg::data_w-1:0]   wdata,
    input  logic [axi_pkg::strb_w-1:0]   wstrb,
    input  logic                         wlast,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [axi_pkg::id_w-1:0]     bid,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    output logic [axi_pkg::id_w-1:0]     m_awid [split_pkg::num_ports],
    output logic [axi_pkg::addr_w-1:0]   m_awaddr [split_pkg::num_ports],
    output logic [7:0]                   m_awlen [split_pkg::num_ports],
    output logic [2:0]                   m_awsize [split_pkg::num_ports],
    output logic [1:0]                   m_awburst [split_pkg::num_ports],
    output logic [axi_pkg::extras_w-1:0] m_awextras [split_pkg::num_ports],
    output logic                         m_awvalid [split_pkg::num_ports],
    input  logic                         m_awready [split_pkg::num_ports],
    output logic [axi_pkg::data_w-1:0]   m_wdata [split_pkg::num_ports],
    output logic [axi_pkg::strb_w-1:0]   m_wstrb [split_pkg::num_ports],
    output logic                         m_wlast [split_pkg::num_ports],
    output logic                         m_wvalid [split_pkg::num_ports],
    input  logic                         m_wready [split_pkg::num_ports],
    input  logic [axi_pkg::id_w-1:0]     m_bid [split_pkg::num_ports],
    input  logic [1:0]                   m_bresp [split_pkg::num_ports],
    input  logic                         m_bvalid [split_pkg::num_ports],
    output logic                         m_bready [split_pkg::num_ports]
);
    axi_pkg::aw_t     aw_in;
    axi_pkg::w_t      w_in;
    axi_pkg::w_t      w_head;
    axi_pkg::b_t      b_out;
    axi_pkg::aw_t     m_aw [split_pkg::num_ports];
    axi_pkg::w_t      m_w [split_pkg::num_ports];
    axi_pkg::b_t      m_b [split_pkg::num_ports];
    logic             w_full;
    logic             w_empty;
    logic             w_pop;
    logic             order_push;
    logic             order_pop;
    logic             order_full;
    logic             order_empty;
    split_pkg::port_t order_port;
    split_pkg::port_t order_head;
    logic             can_issue [split_pkg::num_ports];
    logic             issue [split_pkg::num_ports];
    logic             retire [split_pkg::num_ports];

    assign aw_in = '{id: awid, addr: awaddr, len: awlen, size: awsize,
                     burst: awburst, extras: awextras};
    assign w_in  = '{data: wdata, strb: wstrb, last: wlast};

    sync_fifo #(.payload_t(axi_pkg::w_t), .depth(split_pkg::w_depth)) w_fifo_i (
        .clk(clk), .rst_n(rst_n), .push(wvalid && wready), .din(w_in),
        .pop(w_pop), .dout(w_head), .full(w_full), .empty(w_empty)
    );
    assign wready = !w_full;

    // owner of every issued burst, oldest first, so beats follow command order.
    sync_fifo #(.payload_t(split_pkg::port_t), .depth(split_pkg::order_depth)) order_fifo_i (
        .clk(clk), .rst_n(rst_n), .push(order_push), .din(order_port),
        .pop(order_pop), .dout(order_head), .full(order_full), .empty(order_empty)
    );

    aw_router aw_router_i (
        .clk(clk), .rst_n(rst_n), .awvalid(awvalid), .awready(awready), .aw(aw_in),
        .can_issue(can_issue), .order_full(order_full), .order_push(order_push),
        .order_port(order_port), .m_awvalid(m_awvalid), .m_awready(m_awready),
        .m_aw(m_aw), .issue(issue)
    );

    w_steer w_steer_i (
        .clk(clk), .rst_n(rst_n), .order_empty(order_empty), .order_port(order_head),
        .order_pop(order_pop), .w_empty(w_empty), .w_head(w_head), .w_pop(w_pop),
        .m_wvalid(m_wvalid), .m_wready(m_wready), .m_w(m_w)
    );

    outstanding_counter outstanding_counter_i (
        .clk(clk), .rst_n(rst_n), .issue(issue), .retire(retire), .can_issue(can_issue)
    );

    b_merge b_merge_i (
        .clk(clk), .rst_n(rst_n), .m_bvalid(m_bvalid), .m_bready(m_bready), .m_b(m_b),
        .bvalid(bvalid), .bready(bready), .b(b_out), .retire(retire)
    );

    assign bid   = b_out.id;
    assign bresp = b_out.resp;

    for (genvar p = 0; p < split_pkg::num_ports; p++) begin : g_port
        assign m_awid[p]     = m_aw[p].id;
        assign m_awaddr[p]   = m_aw[p].addr;
        assign m_awlen[p]    = m_aw[p].len;
        assign m_awsize[p]   = m_aw[p].size;
        assign m_awburst[p]  = m_aw[p].burst;
        assign m_awextras[p] = m_aw[p].extras;
        assign m_wdata[p]    = m_w[p].data;
        assign m_wstrb[p]    = m_w[p].strb;
        assign m_wlast[p]    = m_w[p].last;
        assign m_b[p]        = '{id: m_bid[p], resp: m_bresp[p]};
    end

endmodule

// File: tb_port_slave.sv
module tb_port_slave #(
    parameter int port_idx = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     hold_b,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axi_pkg::id_w-1:0] awid,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic                     wlast,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [axi_pkg::id_w-1:0] bid,
    output logic [1:0]               bresp
);
    timeunit 1ns;
    timeprecision 100ps;

    integer                   seed = 15 + port_idx;
    logic [axi_pkg::id_w-1:0] aw_ids [$];  // accepted bursts still missing beats.
    logic [axi_pkg::id_w-1:0] done_ids [$];  // complete bursts waiting for B.
    logic                     aw_rdy = 1'b0;
    logic                     w_rdy = 1'b0;
    logic                     b_vld = 1'b0;
    logic [axi_pkg::id_w-1:0] b_id = '0;
    logic [31:0]              r;

    assign awready = aw_rdy;
    assign wready  = w_rdy;
    assign bvalid  = b_vld;
    assign bid     = b_id;
    assign bresp   = (port_idx == 3) ? axi_pkg::resp_slverr : axi_pkg::resp_okay;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_rdy <= 1'b0;
            w_rdy  <= 1'b0;
            b_vld  <= 1'b0;
            b_id   <= '0;
            aw_ids.delete();
            done_ids.delete();
        end else begin
            if (b_vld && bready) begin
                void'(done_ids.pop_front());
            end
            if (awvalid && aw_rdy) begin
                aw_ids.push_back(awid);
            end
            if (wvalid && w_rdy && wlast && aw_ids.size() > 0) begin
                done_ids.push_back(aw_ids.pop_front());
            end
            r = $random(seed);
            aw_rdy <= (r[1:0] != 2'd0);
            w_rdy  <= (r[3:2] != 2'd0);
            if (b_vld && !bready) begin
                b_vld <= 1'b1;  // hold the response until it is taken.
            end else if (!hold_b && done_ids.size() > 0 && r[4]) begin
                b_vld <= 1'b1;
                b_id  <= done_ids[0];
            end else begin
                b_vld <= 1'b0;
            end
        end
    end

endmodule

// File: tb_axi_wr_splitter.sv
module tb_axi_wr_splitter;
    timeunit 1ns;
    timeprecision 100ps;

    logic                         clk;
    logic                         rst_n;
    logic [axi_pkg::id_w-1:0]     awid;
    logic [axi_pkg::addr_w-1:0]   awaddr;
    logic [7:0]                   awlen;
    logic [2:0]                   awsize;
    logic [1:0]                   awburst;
    logic [axi_pkg::extras_w-1:0] awextras;
    logic                         awvalid;
    logic                         awready;
    logic [axi_pkg::data_w-1:0]   wdata;
    logic [axi_pkg::strb_w-1:0]   wstrb;
    logic                         wlast;
    logic                         wvalid;
    logic                         wready;
    logic [axi_pkg::id_w-1:0]     bid;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    logic [axi_pkg::id_w-1:0]     m_awid [split_pkg::num_ports];
    logic [axi_pkg::addr_w-1:0]   m_awaddr [split_pkg::num_ports];
    logic [7:0]                   m_awlen [split_pkg::num_ports];
    logic [2:0]                   m_awsize [split_pkg::num_ports];
    logic [1:0]                   m_awburst [split_pkg::num_ports];
    logic [axi_pkg::extras_w-1:0] m_awextras [split_pkg::num_ports];
    logic                         m_awvalid [split_pkg::num_ports];
    logic                         m_awready [split_pkg::num_ports];
    logic [axi_pkg::data_w-1:0]   m_wdata [split_pkg::num_ports];
    logic [axi_pkg::strb_w-1:0]   m_wstrb [split_pkg::num_ports];
    logic                         m_wlast [split_pkg::num_ports];
    logic                         m_wvalid [split_pkg::num_ports];
    logic                         m_wready [split_pkg::num_ports];
    logic [axi_pkg::id_w-1:0]     m_bid [split_pkg::num_ports];
    logic [1:0]                   m_bresp [split_pkg::num_ports];
    logic                         m_bvalid [split_pkg::num_ports];
    logic                         m_bready [split_pkg::num_ports];
    logic                         hold_b [split_pkg::num_ports];

    integer           seed = 15;
    int               errors;
    int               tests_run;
    int               tests_failed;
    int               got_b;
    bit               aborted;
    int               out_cnt [split_pkg::num_ports];  // downstream AW minus B per port.
    axi_pkg::aw_t     stim_aw [$];
    axi_pkg::w_t      stim_w [$];
    axi_pkg::aw_t     exp_aw [$];
    split_pkg::port_t exp_aw_port [$];
    axi_pkg::w_t      exp_w [$];
    split_pkg::port_t exp_w_port [$];
    axi_pkg::b_t      exp_b [$];

    axi_wr_splitter dut_i (
        .clk(clk), .rst_n(rst_n), .awid(awid), .awaddr(awaddr), .awlen(awlen),
        .awsize(awsize), .awburst(awburst), .awextras(awextras), .awvalid(awvalid),
        .awready(awready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid),
        .wready(wready), .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .m_awid(m_awid), .m_awaddr(m_awaddr), .m_awlen(m_awlen), .m_awsize(m_awsize),
        .m_awburst(m_awburst), .m_awextras(m_awextras), .m_awvalid(m_awvalid),
        .m_awready(m_awready), .m_wdata(m_wdata), .m_wstrb(m_wstrb), .m_wlast(m_wlast),
        .m_wvalid(m_wvalid), .m_wready(m_wready), .m_bid(m_bid), .m_bresp(m_bresp),
        .m_bvalid(m_bvalid), .m_bready(m_bready)
    );

    for (genvar p = 0; p < split_pkg::num_ports; p++) begin : g_slave
        tb_port_slave #(.port_idx(p)) slave_i (
            .clk(clk), .rst_n(rst_n), .hold_b(hold_b[p]), .awvalid(m_awvalid[p]),
            .awready(m_awready[p]), .awid(m_awid[p]), .wvalid(m_wvalid[p]),
            .wready(m_wready[p]), .wlast(m_wlast[p]), .bvalid(m_bvalid[p]),
            .bready(m_bready[p]), .bid(m_bid[p]), .bresp(m_bresp[p])
        );
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string why);
        if (!aborted) begin
            $display("timeout: %s", why);
        end
        aborted = 1'b1;
    endtask

    // bursts with a random or fixed port, plus what each port should see.
    task automatic make_bursts(input int n, input int port);
        logic [31:0]      r;
        axi_pkg::aw_t     a;
        axi_pkg::aw_t     e;
        axi_pkg::w_t      w;
        axi_pkg::b_t      b;
        split_pkg::port_t p;
        int               ln;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            p = (port < 0) ? r[15:14] : split_pkg::port_t'(port);
            ln = int'(r[13:12]);
            a.id = r[3:0];
            a.extras = r[11:4];
            a.addr = $random(seed);
            a.addr[axi_pkg::addr_w-1 -: split_pkg::sel_w] = p;
            a.len = {6'd0, r[13:12]};
            a.size = 3'd3;
            a.burst = 2'b01;
            e = a;
            e.addr = a.addr << split_pkg::sel_w;  // port bits drop out at the top.
            stim_aw.push_back(a);
            exp_aw.push_back(e);
            exp_aw_port.push_back(p);
            b.id = a.id;
            b.resp = (p == 2'd3) ? axi_pkg::resp_slverr : axi_pkg::resp_okay;
            exp_b.push_back(b);
            for (int k = 0; k <= ln; k++) begin
                r = $random(seed);
                w.data = {$random(seed), $random(seed)};
                w.strb = r[7:0];
                w.last = (k == ln);
                stim_w.push_back(w);
                exp_w.push_back(w);
                exp_w_port.push_back(p);
            end
        end
    endtask

    task automatic wait_accept(input bit w_chan, input int limit, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < limit) begin
            @(negedge clk);
            ok = w_chan ? wready : awready;  // transfer happens at the next rising edge.
            @(posedge clk);
            n++;
        end
    endtask

    task automatic send_aw_all(input int limit);
        bit ok;
        foreach (stim_aw[i]) begin
            if (!aborted) begin
                awid     <= stim_aw[i].id;
                awaddr   <= stim_aw[i].addr;
                awlen    <= stim_aw[i].len;
                awsize   <= stim_aw[i].size;
                awburst  <= stim_aw[i].burst;
                awextras <= stim_aw[i].extras;
                awvalid  <= 1'b1;
                wait_accept(1'b0, limit, ok);
                if (!ok) begin
                    note_timeout("upstream AW channel never accepted a command");
                end
            end
        end
        awvalid <= 1'b0;
    endtask

    task automatic send_w_all(input int limit);
        bit ok;
        foreach (stim_w[i]) begin
            if (!aborted) begin
                wdata  <= stim_w[i].data;
                wstrb  <= stim_w[i].strb;
                wlast  <= stim_w[i].last;
                wvalid <= 1'b1;
                wait_accept(1'b1, limit, ok);
                if (!ok) begin
                    note_timeout("upstream W channel never accepted a beat");
                end
            end
        end
        wvalid <= 1'b0;
    endtask

    task automatic wait_responses(input int limit);
        int n;
        n = 0;
        while (exp_b.size() > 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_b.size() > 0) begin
            note_timeout($sformatf("%0d write responses never came back", exp_b.size()));
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // hold_cycles withholds B at the fixed port, or holds bready low when stall_b is set.
    task automatic run_traffic(input string name, input int n, input int port,
                               input int hold_cycles, input bit stall_b);
        int e0;
        e0 = errors;
        got_b = 0;
        stim_aw.delete();
        stim_w.delete();
        make_bursts(n, port);
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            hold_b[p] <= (hold_cycles > 0) && (p == port);
        end
        bready <= !stall_b;
        fork
            send_aw_all(400);
            send_w_all(400);
            begin
                repeat (hold_cycles) @(posedge clk);
                if (port >= 0 && hold_cycles > 0) begin
                    check($sformatf("outstanding[%0d]", port), out_cnt[port],
                          split_pkg::max_outstanding);
                end
                for (int p = 0; p < split_pkg::num_ports; p++) begin
                    hold_b[p] <= 1'b0;
                end
                bready <= 1'b1;
            end
        join
        if (!aborted) begin
            wait_responses(400);
        end
        check("response count", got_b, n);
        check("aw left over", exp_aw.size(), 0);
        check("w left over", exp_w.size(), 0);
        finish_test(name, e0);
    endtask

    // downstream and upstream handshakes, sampled between clock edges.
    always @(negedge clk) begin
        axi_pkg::aw_t got_aw;
        axi_pkg::w_t  got_w;
        int           idx;
        if (rst_n) begin
            for (int p = 0; p < split_pkg::num_ports; p++) begin
                if (m_bvalid[p] && m_bready[p]) begin
                    out_cnt[p]--;
                end
                if (m_awvalid[p] && m_awready[p]) begin
                    got_aw = '{id: m_awid[p], addr: m_awaddr[p], len: m_awlen[p],
                               size: m_awsize[p], burst: m_awburst[p], extras: m_awextras[p]};
                    out_cnt[p]++;
                    if (exp_aw.size() == 0) begin
                        $display("port %0d took a command that was never sent", p);
                        errors++;
                    end else begin
                        check($sformatf("m_aw[%0d]", p), got_aw, exp_aw.pop_front());
                        check("aw port", p, exp_aw_port.pop_front());
                    end
                    if (out_cnt[p] > split_pkg::max_outstanding) begin
                        $display("port %0d has %0d writes outstanding, over the limit",
                                 p, out_cnt[p]);
                        errors++;
                    end
                end
                if (m_wvalid[p] && m_wready[p]) begin
                    got_w = '{data: m_wdata[p], strb: m_wstrb[p], last: m_wlast[p]};
                    if (exp_w.size() == 0) begin
                        $display("port %0d took a beat that was never sent", p);
                        errors++;
                    end else begin
                        check($sformatf("m_w[%0d]", p), got_w, exp_w.pop_front());
                        check("w port", p, exp_w_port.pop_front());
                    end
                end
            end
            if (bvalid && bready) begin
                idx = -1;
                foreach (exp_b[i]) begin
                    if (idx < 0 && exp_b[i].id == bid && exp_b[i].resp == bresp) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    $display("response id 0x%0h resp 0x%0h was not expected", bid, bresp);
                    errors++;
                end else begin
                    exp_b.delete(idx);
                    got_b++;
                end
            end
        end
    end

    initial begin
        int e0;
        rst_n = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = '0;
        awextras = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        got_b = 0;
        aborted = 1'b0;
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            hold_b[p] = 1'b0;
            out_cnt[p] = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        e0 = errors;
        for (int p = 0; p < split_pkg::num_ports; p++) begin
            check($sformatf("m_awvalid[%0d]", p), m_awvalid[p], 1'b0);
            check($sformatf("m_wvalid[%0d]", p), m_wvalid[p], 1'b0);
        end
        check("bvalid", bvalid, 1'b0);
        finish_test("idle after reset", e0);
        @(posedge clk);
        run_traffic("random traffic", 40, -1, 0, 1'b0);
        if (!aborted) begin
            run_traffic("outstanding limit", 8, 2, 60, 1'b0);
        end
        if (!aborted) begin
            run_traffic("bready back-pressure", 16, -1, 80, 1'b1);
        end
        $display("summary: %0d run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0 && !aborted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
axi_pkg.sv
split_pkg.sv
sync_fifo.sv
aw_router.sv
w_steer.sv
outstanding_counter.sv
b_merge.sv
axi_wr_splitter.sv
tb_port_slave.sv
tb_axi_wr_splitter.sv

// File: Makefile
BIN := obj_dir/Vtb_axi_wr_splitter

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^all tests passed$$" sim.log

$(BIN): sources.f $(shell cat sources.f)
	verilator --binary --timing -Wno-fatal --top-module tb_axi_wr_splitter -f sources.f

clean:
	rm -rf obj_dir sim.log
